//--- compile.f
+incdir+verification
common/mips_pkg.sv
common/mem_if.sv
hw/instr_decoder.sv
cache/dcache_array.sv
cache/dcache_controller.sv
hw/main_memory.sv
hw/mem_stage_top.sv
verification/mem_stage_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing
TOP       := mem_stage_tb
FILELIST  := compile.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TEST PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/mem_stage_tests.svh
// one load or store, checked against the reference memory
task automatic do_access(bit store, mips_pkg::word_t a, mips_pkg::word_t d);
    bit ok;
    present(store ? mips_pkg::OP_SW : mips_pkg::OP_LW, 6'd0, a, d, ok);
    if (ok) begin
        check($sformatf("reg_write accepting %h", a), 32'(reg_write), 32'(!store));
        if (!store) begin
            check($sformatf("load_data at %h", a), load_data, ref_mem[a[WORD_BITS+1:2]]);
        end
    end
endtask

// flags: alu_src, reg_write, jump, branch, jump_register, is_unsigned
task automatic check_decode(string name, mips_pkg::opcode_t op, mips_pkg::func_t fn,
                            mips_pkg::alu_op_t e_alu, int e_dest, int e_src, logic [5:0] flags);
    bit ok;
    present(op, fn, 32'h0000_0040, 32'h0, ok);
    if (ok) begin
        check({name, " alu_op"}, 32'(alu_op), 32'(e_alu));
        check({name, " dest_sel"}, 32'(dest_sel), 32'(e_dest));
        check({name, " reg_src"}, 32'(reg_src), 32'(e_src));
        check({name, " alu_src"}, 32'(alu_src), 32'(flags[5]));
        check({name, " reg_write"}, 32'(reg_write), 32'(flags[4]));
        check({name, " jump"}, 32'(jump), 32'(flags[3]));
        check({name, " branch"}, 32'(branch), 32'(flags[2]));
        check({name, " jump_register"}, 32'(jump_register), 32'(flags[1]));
        check({name, " is_unsigned"}, 32'(is_unsigned), 32'(flags[0]));
    end
endtask

task automatic check_rtype(string name, mips_pkg::func_t fn, mips_pkg::alu_op_t e_alu);
    check_decode(name, mips_pkg::OP_RTYPE, fn, e_alu, 1, 0,
                 {4'b0100, fn == mips_pkg::FN_JR, 1'b0});
endtask

task automatic go_idle();
    @(negedge clk);
    in_valid = 1'b0;
endtask

task automatic finish_test(string name, int errors_before);
    tests_run++;
    $display("%s: %0d errors", name, errors - errors_before);
endtask

task automatic decode_table_test();
    int start;
    start = errors;
    // dest: rt 0, rd 1, ra 2   reg_src: alu 0, mem 1, pc 2
    check_decode("addi", mips_pkg::OP_ADDI, 6'd0, mips_pkg::ALU_ADD, 0, 0, 6'b110000);
    check_decode("addiu", mips_pkg::OP_ADDIU, 6'd0, mips_pkg::ALU_ADD, 0, 0, 6'b110001);
    check_decode("andi", mips_pkg::OP_ANDI, 6'd0, mips_pkg::ALU_AND, 0, 0, 6'b110001);
    check_decode("xori", mips_pkg::OP_XORI, 6'd0, mips_pkg::ALU_XOR, 0, 0, 6'b110001);
    check_decode("ori", mips_pkg::OP_ORI, 6'd0, mips_pkg::ALU_OR, 0, 0, 6'b110001);
    check_decode("slti", mips_pkg::OP_SLTI, 6'd0, mips_pkg::ALU_SLT, 0, 0, 6'b110000);
    check_decode("lui", mips_pkg::OP_LUI, 6'd0, mips_pkg::ALU_LUI, 0, 0, 6'b110001);
    check_decode("beq", mips_pkg::OP_BEQ, 6'd0, mips_pkg::ALU_BEQ, 0, 0, 6'b100100);
    check_decode("bne", mips_pkg::OP_BNE, 6'd0, mips_pkg::ALU_BNE, 0, 0, 6'b100100);
    check_decode("blez", mips_pkg::OP_BLEZ, 6'd0, mips_pkg::ALU_BLEZ, 0, 0, 6'b100100);
    check_decode("bgtz", mips_pkg::OP_BGTZ, 6'd0, mips_pkg::ALU_BGTZ, 0, 0, 6'b100100);
    check_decode("bgez", mips_pkg::OP_BGEZ, 6'd0, mips_pkg::ALU_BGEZ, 0, 0, 6'b100100);
    check_decode("j", mips_pkg::OP_J, 6'd0, mips_pkg::ALU_ADD, 0, 0, 6'b001000);
    check_decode("jal", mips_pkg::OP_JAL, 6'd0, mips_pkg::ALU_ADD, 2, 2, 6'b011000);
    check_decode("lw", mips_pkg::OP_LW, 6'd0, mips_pkg::ALU_ADD, 0, 1, 6'b110000); // cold miss
    check_decode("sw", mips_pkg::OP_SW, 6'd0, mips_pkg::ALU_ADD, 0, 0, 6'b100000);
    check_rtype("xor", mips_pkg::FN_XOR, mips_pkg::ALU_XOR);
    check_rtype("sll", mips_pkg::FN_SLL, mips_pkg::ALU_SLL);
    check_rtype("sllv", mips_pkg::FN_SLLV, mips_pkg::ALU_SLLV);
    check_rtype("srl", mips_pkg::FN_SRL, mips_pkg::ALU_SRL);
    check_rtype("srlv", mips_pkg::FN_SRLV, mips_pkg::ALU_SRLV);
    check_rtype("sra", mips_pkg::FN_SRA, mips_pkg::ALU_SRA);
    check_rtype("add", mips_pkg::FN_ADD, mips_pkg::ALU_ADD);
    check_rtype("addu", mips_pkg::FN_ADDU, mips_pkg::ALU_ADD);
    check_rtype("sub", mips_pkg::FN_SUB, mips_pkg::ALU_SUB);
    check_rtype("subu", mips_pkg::FN_SUBU, mips_pkg::ALU_SUB);
    check_rtype("mult", mips_pkg::FN_MULT, mips_pkg::ALU_MULT);
    check_rtype("div", mips_pkg::FN_DIV, mips_pkg::ALU_DIV);
    check_rtype("or", mips_pkg::FN_OR, mips_pkg::ALU_OR);
    check_rtype("nor", mips_pkg::FN_NOR, mips_pkg::ALU_NOR);
    check_rtype("and", mips_pkg::FN_AND, mips_pkg::ALU_AND);
    check_rtype("slt", mips_pkg::FN_SLT, mips_pkg::ALU_SLT);
    check_rtype("jr", mips_pkg::FN_JR, mips_pkg::ALU_JR);
    check_rtype("unknown func", 6'b111111, mips_pkg::ALU_ADD);
    go_idle();
    finish_test("decode table", start);
endtask

task automatic load_miss_test();
    int              start;
    mips_pkg::word_t a;
    start = errors;
    a     = random_addr(1'b1); // lines 4..7 still invalid
    do_access(1'b0, a, 32'h0);
    do_access(1'b0, a, 32'h0); // now a hit
    go_idle();
    finish_test("load miss clean line", start);
endtask

task automatic store_load_test();
    int              start;
    mips_pkg::word_t a;
    mips_pkg::word_t d;
    start = errors;
    a     = random_addr(1'b1);
    d     = take_bits(32);
    do_access(1'b1, a, d);
    do_access(1'b0, a, 32'h0);
    go_idle();
    finish_test("store then load", start);
endtask

task automatic dirty_evict_test();
    int              start;
    mips_pkg::word_t a;
    mips_pkg::word_t b;
    mips_pkg::word_t d;
    logic [31:0]     r;
    start = errors;
    a     = random_addr(1'b1);
    r     = take_bits(4);
    b     = a ^ {22'd0, r[3:0], 1'b1, 5'd0}; // same index, other tag
    d     = take_bits(32);
    do_access(1'b1, a, d);
    do_access(1'b0, b, 32'h0);
    do_access(1'b0, a, 32'h0); // only correct if the victim reached memory
    go_idle();
    finish_test("dirty eviction", start);
endtask

task automatic random_traffic_test();
    int              start;
    mips_pkg::word_t a;
    mips_pkg::word_t d;
    logic [31:0]     r;
    start = errors;
    for (int i = 0; i < 200 && !timed_out; i++) begin
        r = take_bits(1);
        a = random_addr(1'b0); // four lines, 32 tags each
        d = take_bits(32);
        do_access(r[0], a, d);
    end
    go_idle();
    finish_test("random traffic", start);
endtask

task automatic idle_decode_test();
    int                start;
    mips_pkg::opcode_t ops [17];
    start = errors;
    ops   = '{mips_pkg::OP_RTYPE, mips_pkg::OP_ADDI, mips_pkg::OP_ADDIU, mips_pkg::OP_ANDI,
              mips_pkg::OP_XORI, mips_pkg::OP_ORI, mips_pkg::OP_LW, mips_pkg::OP_SW,
              mips_pkg::OP_BEQ, mips_pkg::OP_BNE, mips_pkg::OP_BLEZ, mips_pkg::OP_BGTZ,
              mips_pkg::OP_BGEZ, mips_pkg::OP_SLTI, mips_pkg::OP_LUI, mips_pkg::OP_J,
              mips_pkg::OP_JAL};
    foreach (ops[i]) begin
        @(negedge clk);
        in_valid = 1'b0;
        opcode   = ops[i];
        func     = mips_pkg::FN_ADD;
        addr     = random_addr(1'b1);
        #1;
        check($sformatf("reg_write idle op %h", ops[i]), 32'(reg_write), 32'd0);
        check($sformatf("in_ready idle op %h", ops[i]), 32'(in_ready), 32'd1);
    end
    finish_test("no in_valid", start);
endtask

//--- verification/mem_stage_tb.sv
module mem_stage_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int INDEX_BITS    = 3;
    localparam int MEM_WORDS     = 256;
    localparam int MEM_LATENCY   = 4;
    localparam int LINES         = 1 << INDEX_BITS;
    localparam int WORD_BITS     = $clog2(MEM_WORDS);
    localparam int READY_TIMEOUT = 100;

    logic                clk;
    logic                reset;
    logic                in_valid;
    mips_pkg::opcode_t   opcode;
    mips_pkg::func_t     func;
    mips_pkg::word_t     addr;
    mips_pkg::word_t     store_data;
    logic                in_ready;
    mips_pkg::alu_op_t   alu_op;
    logic                alu_src;
    mips_pkg::dest_sel_t dest_sel;
    mips_pkg::reg_src_t  reg_src;
    logic                reg_write;
    logic                jump;
    logic                branch;
    logic                jump_register;
    logic                is_unsigned;
    mips_pkg::word_t     load_data;

    logic [31:0] lfsr_state;
    int          errors;
    int          checks;
    int          tests_run;
    bit          timed_out;

    // architectural memory, and the tag each cache line should hold
    mips_pkg::word_t        ref_mem [MEM_WORDS];
    logic [29-INDEX_BITS:0] ref_tag [LINES];
    bit                     ref_valid [LINES];

    mem_stage_top #(
        .INDEX_BITS  (INDEX_BITS),
        .MEM_WORDS   (MEM_WORDS),
        .MEM_LATENCY (MEM_LATENCY)
    ) mem_stage_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] take_bits(int n);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            bits       = {bits[30:0], fb};
        end
        return bits;
    endfunction

    // word address inside main memory; high_lines picks index 4..7, else 0..3
    function automatic mips_pkg::word_t random_addr(bit high_lines);
        logic [31:0] tag_bits;
        logic [31:0] idx_bits;
        tag_bits = take_bits(5);
        idx_bits = take_bits(2);
        return {22'd0, tag_bits[4:0], high_lines, idx_bits[1:0], 2'b00};
    endfunction

    task automatic check(string what, logic [31:0] got, logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("FAIL at %0d ns: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    function automatic bit model_hit(mips_pkg::word_t a);
        return ref_valid[a[INDEX_BITS+1:2]] && (ref_tag[a[INDEX_BITS+1:2]] == a[31:INDEX_BITS+2]);
    endfunction

    // drive one instruction and wait until it is accepted
    task automatic present(mips_pkg::opcode_t op, mips_pkg::func_t fn, mips_pkg::word_t a,
                           mips_pkg::word_t d, output bit ok);
        bit mem_op;
        bit expect_ready;
        int waited;
        mem_op       = (op == mips_pkg::OP_LW) || (op == mips_pkg::OP_SW);
        expect_ready = !mem_op || model_hit(a);
        @(negedge clk);
        in_valid   = 1'b1;
        opcode     = op;
        func       = fn;
        addr       = a;
        store_data = d;
        #1;
        check($sformatf("in_ready on op %h addr %h", op, a), 32'(in_ready), 32'(expect_ready));
        waited = 0;
        while (!in_ready && waited < READY_TIMEOUT) begin
            check("reg_write during stall", 32'(reg_write), 32'd0);
            @(negedge clk);
            #1;
            waited++;
        end
        ok = in_ready;
        if (!in_ready) begin
            $display("timeout: in_ready stayed low for %0d cycles on op %h address %h",
                     READY_TIMEOUT, op, a);
            timed_out = 1'b1;
        end else if (mem_op) begin
            ref_valid[a[INDEX_BITS+1:2]] = 1'b1;
            ref_tag[a[INDEX_BITS+1:2]]   = a[31:INDEX_BITS+2];
            if (op == mips_pkg::OP_SW) begin
                ref_mem[a[WORD_BITS+1:2]] = d;
            end
        end
    endtask

    `include "mem_stage_tests.svh"

    initial begin
        reset      = 1'b1;
        in_valid   = 1'b0;
        opcode     = '0;
        func       = '0;
        addr       = '0;
        store_data = '0;
        lfsr_state = 32'hf4eb8c7f;
        errors     = 0;
        checks     = 0;
        tests_run  = 0;
        timed_out  = 1'b0;
        foreach (ref_mem[i]) begin
            ref_mem[i] = '0; // memory clears on reset
        end
        foreach (ref_valid[i]) begin
            ref_valid[i] = 1'b0;
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        decode_table_test();
        if (!timed_out) load_miss_test();
        if (!timed_out) store_load_test();
        if (!timed_out) dirty_evict_test();
        if (!timed_out) random_traffic_test();
        if (!timed_out) idle_decode_test();

        $display("summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- hw/mem_stage_top.sv
module mem_stage_top #(
    parameter int INDEX_BITS  = 3,
    parameter int MEM_WORDS   = 256,
    parameter int MEM_LATENCY = 4
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                in_valid,
    input  mips_pkg::opcode_t   opcode,
    input  mips_pkg::func_t     func,
    input  mips_pkg::word_t     addr,
    input  mips_pkg::word_t     store_data,
    output logic                in_ready,
    output mips_pkg::alu_op_t   alu_op,
    output logic                alu_src,
    output mips_pkg::dest_sel_t dest_sel,
    output mips_pkg::reg_src_t  reg_src,
    output logic                reg_write,
    output logic                jump,
    output logic                branch,
    output logic                jump_register,
    output logic                is_unsigned,
    output mips_pkg::word_t     load_data
);

    logic            decoded_reg_write;
    logic            is_load;
    logic            is_store;
    logic            hit;
    logic            dirty;
    mips_pkg::word_t victim_addr;
    mips_pkg::word_t cache_rdata;
    logic            cache_write_en;
    mips_pkg::word_t cache_write_data;
    logic            cache_write_dirty;
    logic            reg_write_load;

    mem_if mem_bus ();

    // lw only writes back in its accepting cycle
    assign reg_write = (in_valid && decoded_reg_write) || reg_write_load;
    assign load_data = cache_rdata;

    instr_decoder instr_decoder_inst (
        .opcode            (opcode),
        .func              (func),
        .alu_op            (alu_op),
        .alu_src           (alu_src),
        .dest_sel          (dest_sel),
        .reg_src           (reg_src),
        .decoded_reg_write (decoded_reg_write),
        .jump              (jump),
        .branch            (branch),
        .jump_register     (jump_register),
        .is_unsigned       (is_unsigned),
        .is_load           (is_load),
        .is_store          (is_store)
    );

    dcache_array #(
        .INDEX_BITS (INDEX_BITS)
    ) dcache_array_inst (
        .clk         (clk),
        .reset       (reset),
        .lookup_addr (addr),
        .hit         (hit),
        .dirty       (dirty),
        .victim_addr (victim_addr),
        .rdata       (cache_rdata),
        .write_en    (cache_write_en),
        .write_data  (cache_write_data),
        .write_dirty (cache_write_dirty)
    );

    dcache_controller #(
        .INDEX_BITS (INDEX_BITS)
    ) dcache_controller_inst (
        .clk               (clk),
        .reset             (reset),
        .in_valid          (in_valid),
        .is_load           (is_load),
        .is_store          (is_store),
        .addr              (addr),
        .store_data        (store_data),
        .hit               (hit),
        .dirty             (dirty),
        .victim_addr       (victim_addr),
        .cache_rdata       (cache_rdata),
        .cache_write_en    (cache_write_en),
        .cache_write_data  (cache_write_data),
        .cache_write_dirty (cache_write_dirty),
        .in_ready          (in_ready),
        .reg_write_load    (reg_write_load),
        .mem               (mem_bus.master)
    );

    main_memory #(
        .MEM_WORDS   (MEM_WORDS),
        .MEM_LATENCY (MEM_LATENCY)
    ) main_memory_inst (
        .clk   (clk),
        .reset (reset),
        .mem   (mem_bus.slave)
    );

endmodule

//--- hw/main_memory.sv
module main_memory #(
    parameter int MEM_WORDS   = 256,
    parameter int MEM_LATENCY = 4
) (
    input  logic  clk,
    input  logic  reset,
    mem_if.slave  mem
);

    localparam int ADDR_BITS = $clog2(MEM_WORDS);
    localparam int CNT_BITS  = $clog2(MEM_LATENCY + 1);

    mips_pkg::word_t       words [MEM_WORDS];
    logic [CNT_BITS-1:0]   count;
    logic                  busy;
    logic [ADDR_BITS-1:0]  word_index;

    assign word_index = mem.addr[ADDR_BITS+1:2];
    assign mem.done   = busy && (count == '0);
    assign mem.rdata  = words[word_index];

    always_ff @(posedge clk) begin
        if (reset) begin
            busy  <= 1'b0;
            count <= '0;
            for (int i = 0; i < MEM_WORDS; i++) begin
                words[i] <= '0;
            end
        end else if (mem.req) begin
            busy  <= 1'b1;
            count <= CNT_BITS'(MEM_LATENCY - 1); // done lands MEM_LATENCY after req
        end else if (busy) begin
            if (count == '0) begin
                busy <= 1'b0;
                if (mem.we) begin
                    words[word_index] <= mem.wdata; // commit on done
                end
            end else begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- cache/dcache_controller.sv
module dcache_controller #(
    parameter int INDEX_BITS = 3
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            in_valid,
    input  logic            is_load,
    input  logic            is_store,
    input  mips_pkg::word_t addr,
    input  mips_pkg::word_t store_data,
    input  logic            hit,
    input  logic            dirty,
    input  mips_pkg::word_t victim_addr,
    input  mips_pkg::word_t cache_rdata,
    output logic            cache_write_en,
    output mips_pkg::word_t cache_write_data,
    output logic            cache_write_dirty,
    output logic            in_ready,
    output logic            reg_write_load,
    mem_if.master           mem
);

    localparam int TAG_LSB = INDEX_BITS + 2;

    typedef enum logic [1:0] {
        IDLE,
        WB_WAIT,
        REFILL_REQ,
        REFILL_WAIT
    } state_t;

    state_t          state;
    logic            mem_access;
    logic            miss;
    mips_pkg::word_t refill_addr;
    logic            req_q;
    logic            we_q;
    mips_pkg::word_t addr_q;
    mips_pkg::word_t wdata_q;

    assign mem_access  = in_valid && (is_load || is_store);
    assign miss        = mem_access && !hit;
    assign refill_addr = {addr[31:TAG_LSB], addr[TAG_LSB-1:2], 2'b00};

    // retire in idle unless the access misses
    assign in_ready       = (state == IDLE) && !miss;
    assign reg_write_load = (state == IDLE) && in_valid && is_load && hit;

    // store hit writes dirty, refill writes clean
    assign cache_write_en    = ((state == IDLE) && in_valid && is_store && hit) ||
                               ((state == REFILL_WAIT) && mem.done);
    assign cache_write_data  = (state == REFILL_WAIT) ? mem.rdata : store_data;
    assign cache_write_dirty = (state == IDLE);

    assign mem.req   = req_q;
    assign mem.we    = we_q;
    assign mem.addr  = addr_q;
    assign mem.wdata = wdata_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
            req_q <= 1'b0;
            we_q  <= 1'b0;
        end else begin
            req_q <= 1'b0;
            case (state)
                IDLE: begin
                    if (miss) begin
                        req_q <= 1'b1;
                        if (dirty) begin
                            we_q  <= 1'b1; // victim goes out first
                            state <= WB_WAIT;
                        end else begin
                            we_q  <= 1'b0;
                            state <= REFILL_REQ;
                        end
                    end
                end
                WB_WAIT: begin
                    if (mem.done) begin
                        req_q <= 1'b1;
                        we_q  <= 1'b0;
                        state <= REFILL_REQ;
                    end
                end
                REFILL_REQ: state <= REFILL_WAIT; // req is high this cycle
                REFILL_WAIT: begin
                    if (mem.done) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // memory address and data held until done
    always_ff @(posedge clk) begin
        if ((state == IDLE) && miss) begin
            addr_q  <= dirty ? victim_addr : refill_addr;
            wdata_q <= cache_rdata;
        end else if ((state == WB_WAIT) && mem.done) begin
            addr_q <= refill_addr;
        end
    end

endmodule

//--- cache/dcache_array.sv
module dcache_array #(
    parameter int INDEX_BITS = 3
) (
    input  logic            clk,
    input  logic            reset,
    input  mips_pkg::word_t lookup_addr,
    output logic            hit,
    output logic            dirty,
    output mips_pkg::word_t victim_addr,
    output mips_pkg::word_t rdata,
    input  logic            write_en,
    input  mips_pkg::word_t write_data,
    input  logic            write_dirty
);

    localparam int LINES    = 1 << INDEX_BITS;
    localparam int TAG_BITS = 30 - INDEX_BITS; // one word per line

    logic [LINES-1:0]      valid_bits;
    logic [LINES-1:0]      dirty_bits;
    logic [TAG_BITS-1:0]   tags [LINES];
    mips_pkg::word_t       data [LINES];

    logic [INDEX_BITS-1:0] index;
    logic [TAG_BITS-1:0]   tag;

    assign index = lookup_addr[INDEX_BITS+1:2];
    assign tag   = lookup_addr[31:INDEX_BITS+2];

    assign hit         = valid_bits[index] && (tags[index] == tag);
    assign dirty       = valid_bits[index] && dirty_bits[index];
    assign victim_addr = {tags[index], index, 2'b00}; // address of the resident line
    assign rdata       = data[index];

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (write_en) begin
            valid_bits[index] <= 1'b1;
            dirty_bits[index] <= write_dirty;
        end
    end

    // tag follows the address being written
    always_ff @(posedge clk) begin
        if (write_en) begin
            tags[index] <= tag;
            data[index] <= write_data;
        end
    end

endmodule

//--- hw/instr_decoder.sv
module instr_decoder (
    input  mips_pkg::opcode_t   opcode,
    input  mips_pkg::func_t     func,
    output mips_pkg::alu_op_t   alu_op,
    output logic                alu_src,
    output mips_pkg::dest_sel_t dest_sel,
    output mips_pkg::reg_src_t  reg_src,
    output logic                decoded_reg_write,
    output logic                jump,
    output logic                branch,
    output logic                jump_register,
    output logic                is_unsigned,
    output logic                is_load,
    output logic                is_store
);

    always_comb begin
        // i-type defaults, rt and immediate
        alu_op            = mips_pkg::ALU_ADD;
        alu_src           = 1'b1;
        dest_sel          = mips_pkg::DEST_RT;
        reg_src           = mips_pkg::REG_SRC_ALU;
        decoded_reg_write = 1'b1;
        jump              = 1'b0;
        branch            = 1'b0;
        jump_register     = 1'b0;
        is_unsigned       = 1'b0;
        is_load           = 1'b0;
        is_store          = 1'b0;

        case (opcode)
            mips_pkg::OP_RTYPE: begin
                dest_sel = mips_pkg::DEST_RD;
                alu_src  = 1'b0;
                case (func)
                    mips_pkg::FN_XOR:  alu_op = mips_pkg::ALU_XOR;
                    mips_pkg::FN_SLL:  alu_op = mips_pkg::ALU_SLL;
                    mips_pkg::FN_SLLV: alu_op = mips_pkg::ALU_SLLV;
                    mips_pkg::FN_SRL:  alu_op = mips_pkg::ALU_SRL;
                    mips_pkg::FN_SRLV: alu_op = mips_pkg::ALU_SRLV;
                    mips_pkg::FN_SRA:  alu_op = mips_pkg::ALU_SRA;
                    mips_pkg::FN_ADD,
                    mips_pkg::FN_ADDU: alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::FN_SUB,
                    mips_pkg::FN_SUBU: alu_op = mips_pkg::ALU_SUB;
                    mips_pkg::FN_MULT: alu_op = mips_pkg::ALU_MULT; // hi/lo not modelled
                    mips_pkg::FN_DIV:  alu_op = mips_pkg::ALU_DIV;
                    mips_pkg::FN_OR:   alu_op = mips_pkg::ALU_OR;
                    mips_pkg::FN_NOR:  alu_op = mips_pkg::ALU_NOR;
                    mips_pkg::FN_AND:  alu_op = mips_pkg::ALU_AND;
                    mips_pkg::FN_SLT:  alu_op = mips_pkg::ALU_SLT;
                    mips_pkg::FN_JR: begin
                        alu_op        = mips_pkg::ALU_JR;
                        jump_register = 1'b1;
                    end
                    default: alu_op = mips_pkg::ALU_ADD;
                endcase
            end
            mips_pkg::OP_ADDI:  alu_op = mips_pkg::ALU_ADD;
            mips_pkg::OP_ADDIU: is_unsigned = 1'b1;
            mips_pkg::OP_ANDI: begin
                alu_op      = mips_pkg::ALU_AND;
                is_unsigned = 1'b1;
            end
            mips_pkg::OP_XORI: begin
                alu_op      = mips_pkg::ALU_XOR;
                is_unsigned = 1'b1;
            end
            mips_pkg::OP_ORI: begin
                alu_op      = mips_pkg::ALU_OR;
                is_unsigned = 1'b1;
            end
            mips_pkg::OP_LW: begin
                reg_src           = mips_pkg::REG_SRC_MEM;
                decoded_reg_write = 1'b0; // raised by the cache at retire
                is_load           = 1'b1;
            end
            mips_pkg::OP_SW: begin
                decoded_reg_write = 1'b0;
                is_store          = 1'b1;
            end
            mips_pkg::OP_BEQ, mips_pkg::OP_BNE, mips_pkg::OP_BLEZ,
            mips_pkg::OP_BGTZ, mips_pkg::OP_BGEZ: begin
                branch            = 1'b1;
                decoded_reg_write = 1'b0;
                case (opcode)
                    mips_pkg::OP_BEQ:  alu_op = mips_pkg::ALU_BEQ;
                    mips_pkg::OP_BNE:  alu_op = mips_pkg::ALU_BNE;
                    mips_pkg::OP_BLEZ: alu_op = mips_pkg::ALU_BLEZ;
                    mips_pkg::OP_BGTZ: alu_op = mips_pkg::ALU_BGTZ;
                    default:           alu_op = mips_pkg::ALU_BGEZ;
                endcase
            end
            mips_pkg::OP_SLTI: alu_op = mips_pkg::ALU_SLT;
            mips_pkg::OP_LUI: begin
                alu_op      = mips_pkg::ALU_LUI;
                is_unsigned = 1'b1;
            end
            mips_pkg::OP_J: begin
                jump              = 1'b1;
                alu_src           = 1'b0;
                decoded_reg_write = 1'b0;
            end
            mips_pkg::OP_JAL: begin
                jump     = 1'b1;
                alu_src  = 1'b0;
                dest_sel = mips_pkg::DEST_RA;
                reg_src  = mips_pkg::REG_SRC_PC; // return address
            end
            default: alu_op = mips_pkg::ALU_XOR;
        endcase
    end

endmodule

//--- common/mem_if.sv
interface mem_if;

    logic            req;   // single cycle pulse
    logic            we;
    mips_pkg::word_t addr;
    mips_pkg::word_t wdata;
    mips_pkg::word_t rdata; // valid with done
    logic            done;

    modport master (
        output req, we, addr, wdata,
        input  rdata, done
    );

    modport slave (
        input  req, we, addr, wdata,
        output rdata, done
    );

endinterface

//--- common/mips_pkg.sv
package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  func_t;
    typedef logic [4:0]  alu_op_t;
    typedef logic [1:0]  dest_sel_t;
    typedef logic [1:0]  reg_src_t;

    localparam opcode_t OP_RTYPE = 6'b000000;
    localparam opcode_t OP_ADDI  = 6'b001000;
    localparam opcode_t OP_ADDIU = 6'b001001;
    localparam opcode_t OP_ANDI  = 6'b001100;
    localparam opcode_t OP_XORI  = 6'b001110;
    localparam opcode_t OP_ORI   = 6'b001101;
    localparam opcode_t OP_LW    = 6'b100011;
    localparam opcode_t OP_SW    = 6'b101011;
    localparam opcode_t OP_BEQ   = 6'b000100;
    localparam opcode_t OP_BNE   = 6'b000101;
    localparam opcode_t OP_BLEZ  = 6'b000110;
    localparam opcode_t OP_BGTZ  = 6'b000111;
    localparam opcode_t OP_BGEZ  = 6'b000001; // regimm
    localparam opcode_t OP_SLTI  = 6'b001010;
    localparam opcode_t OP_LUI   = 6'b001111;
    localparam opcode_t OP_J     = 6'b000010;
    localparam opcode_t OP_JAL   = 6'b000011;

    localparam func_t FN_XOR  = 6'b100110;
    localparam func_t FN_SLL  = 6'b000000;
    localparam func_t FN_SLLV = 6'b000100;
    localparam func_t FN_SRL  = 6'b000010;
    localparam func_t FN_SRLV = 6'b000110;
    localparam func_t FN_SRA  = 6'b000011;
    localparam func_t FN_ADD  = 6'b100000;
    localparam func_t FN_ADDU = 6'b100001;
    localparam func_t FN_SUB  = 6'b100010;
    localparam func_t FN_SUBU = 6'b100011;
    localparam func_t FN_MULT = 6'b011000;
    localparam func_t FN_DIV  = 6'b011010;
    localparam func_t FN_OR   = 6'b100101;
    localparam func_t FN_NOR  = 6'b100111;
    localparam func_t FN_AND  = 6'b100100;
    localparam func_t FN_SLT  = 6'b101010;
    localparam func_t FN_JR   = 6'b001000;

    localparam alu_op_t ALU_XOR  = 5'd0;
    localparam alu_op_t ALU_SLL  = 5'd1;
    localparam alu_op_t ALU_SRL  = 5'd2;
    localparam alu_op_t ALU_SRA  = 5'd3;
    localparam alu_op_t ALU_ADD  = 5'd4;
    localparam alu_op_t ALU_SUB  = 5'd5;
    localparam alu_op_t ALU_MULT = 5'd6;
    localparam alu_op_t ALU_DIV  = 5'd7;
    localparam alu_op_t ALU_OR   = 5'd8;
    localparam alu_op_t ALU_NOR  = 5'd9;
    localparam alu_op_t ALU_AND  = 5'd10;
    localparam alu_op_t ALU_SLT  = 5'd11;
    localparam alu_op_t ALU_JR   = 5'd12;
    localparam alu_op_t ALU_BEQ  = 5'd13;
    localparam alu_op_t ALU_BNE  = 5'd14;
    localparam alu_op_t ALU_BLEZ = 5'd15;
    localparam alu_op_t ALU_BGTZ = 5'd16;
    localparam alu_op_t ALU_BGEZ = 5'd17;
    localparam alu_op_t ALU_LUI  = 5'd18;
    localparam alu_op_t ALU_SLLV = 5'd25;
    localparam alu_op_t ALU_SRLV = 5'd26;

    localparam dest_sel_t DEST_RT = 2'd0;
    localparam dest_sel_t DEST_RD = 2'd1;
    localparam dest_sel_t DEST_RA = 2'd2; // link register for jal

    localparam reg_src_t REG_SRC_ALU = 2'd0;
    localparam reg_src_t REG_SRC_MEM = 2'd1;
    localparam reg_src_t REG_SRC_PC  = 2'd2;

endpackage
